// ==== design/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// APB bus widths.
`define DATA_WIDTH 32
`define ADDR_WIDTH 4

// Entries per FIFO.
`define FIFO_DEPTH 4

// Word register offsets.
`define DATA_OFFSET    4'h0
`define STATUS_OFFSET  4'h4
`define CNTRL_OFFSET   4'h8
`define BAUDDIV_OFFSET 4'hC

`endif

// ==== design/uartPkg.sv ====
`default_nettype none

package uartPkg;

  // Slave view of the APB transfer.
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    ERROR
  } apbPhase;

  typedef enum logic [2:0] {
    DATA,
    STATUS,
    CNTRL,
    BAUDDIV,
    NONE
  } regSel;

  typedef struct packed {
    logic [7:0] data;
    logic       frameErr;  // Stop bit was sampled low.
  } rxEntry;

  localparam int statTxFull   = 0;
  localparam int statRxAvail  = 1;
  localparam int statFrameErr = 2;
  localparam int statTxBusy   = 3;

  localparam int ctrlTxEn = 0;
  localparam int ctrlRxEn = 1;  // Bits 3:2 are spare.

endpackage

`default_nettype wire

// ==== design/regBusIf.sv ====
`default_nettype none
`include "uart_params.svh"

interface regBusIf;
  import uartPkg::*;

  regSel                  sel;
  logic                   access;  // Access phase of a legal transfer.
  logic                   write;
  logic [`DATA_WIDTH-1:0] wdata;
  logic                   fault;   // Sequencing or address error.
  logic                   done;    // Access phase with PREADY high.

  modport decoder (output sel, access, write, wdata, fault, input done);

  modport result (input sel, access, write, fault, output done);

  modport execute (input sel, access, write, wdata, fault, done);

endinterface

`default_nettype wire

// ==== design/apbDecode.sv ====
`default_nettype none
`include "uart_params.svh"

module apbDecode (
  input wire logic                   PCLK,
  input wire logic                   PRESETn,
  input wire logic                   PSEL,
  input wire logic                   PENABLE,
  input wire logic                   PWRITE,
  input wire logic [`ADDR_WIDTH-1:0] PADDR,
  input wire logic [`DATA_WIDTH-1:0] PWDATA,
  regBusIf.decoder                   bus
);
  import uartPkg::*;

  apbPhase state;
  apbPhase nextState;
  regSel   addrSel;
  logic    enabled;
  logic    inTransfer;
  logic    addrBad;

  assign enabled    = PSEL & PENABLE;
  assign inTransfer = (state == SETUP) || (state == ACCESS);  // A setup came first.

  always_comb begin
    case (PADDR)
      `DATA_OFFSET:    addrSel = DATA;
      `STATUS_OFFSET:  addrSel = STATUS;
      `CNTRL_OFFSET:   addrSel = CNTRL;
      `BAUDDIV_OFFSET: addrSel = BAUDDIV;
      default:         addrSel = NONE;
    endcase
  end

  assign addrBad = (PADDR[1:0] != 2'b00) || (addrSel == NONE);

  // SETUP means the previous cycle was a setup phase, so PENABLE is due now.
  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (PSEL && !PENABLE) begin
          nextState = SETUP;
        end else if (enabled) begin
          nextState = ERROR;  // Access without setup.
        end
      end
      SETUP, ACCESS: begin
        if (!enabled) begin
          nextState = ERROR;
        end else if (bus.done) begin
          nextState = IDLE;
        end else begin
          nextState = ACCESS;  // Wait state.
        end
      end
      default: begin
        if (!PSEL && !PENABLE) begin
          nextState = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign bus.sel    = addrSel;
  assign bus.write  = PWRITE;
  assign bus.wdata  = PWDATA;
  assign bus.access = enabled & inTransfer & ~addrBad;
  assign bus.fault  = enabled & (~inTransfer | addrBad);

endmodule

`default_nettype wire

// ==== design/regExecute.sv ====
`default_nettype none
`include "uart_params.svh"

module regExecute (
  input wire logic                    PCLK,
  input wire logic                    PRESETn,
  regBusIf.execute                    bus,
  input wire logic                    txFull,
  input wire logic                    rxEmpty,
  input wire uartPkg::rxEntry         rxHead,
  input wire logic                    txBusy,
  output logic                        txPush,
  output logic                        rxPop,
  output logic                        txEn,
  output logic                        rxEn,
  output logic [19:0]                 baudDiv,
  output logic [`DATA_WIDTH-1:0]      regRead
);
  import uartPkg::*;

  logic [3:0] cntrl;
  logic [3:0] status;
  logic       commit;

  assign commit = bus.done & ~bus.fault;  // Completed legal transfer.

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      cntrl   <= '0;
      baudDiv <= '0;
    end else if (commit && bus.write) begin
      if (bus.sel == CNTRL) begin
        cntrl <= bus.wdata[3:0];
      end
      if (bus.sel == BAUDDIV) begin
        baudDiv <= bus.wdata[19:0];
      end
    end
  end

  assign txPush = commit & bus.write & (bus.sel == DATA);
  assign rxPop  = commit & ~bus.write & (bus.sel == DATA);
  assign txEn   = cntrl[ctrlTxEn];
  assign rxEn   = cntrl[ctrlRxEn];

  always_comb begin
    status[statTxFull]   = txFull;
    status[statRxAvail]  = ~rxEmpty;
    status[statFrameErr] = ~rxEmpty & rxHead.frameErr;  // Only meaningful with data.
    status[statTxBusy]   = txBusy;
  end

  always_comb begin
    case (bus.sel)
      DATA:    regRead = `DATA_WIDTH'(rxHead.data);
      STATUS:  regRead = `DATA_WIDTH'(status);
      CNTRL:   regRead = `DATA_WIDTH'(cntrl);
      BAUDDIV: regRead = `DATA_WIDTH'(baudDiv);
      default: regRead = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/apbResult.sv ====
`default_nettype none
`include "uart_params.svh"

module apbResult (
  regBusIf.result                    bus,
  input wire logic                   txFull,
  input wire logic                   rxEmpty,
  input wire logic [`DATA_WIDTH-1:0] regRead,
  output logic                       PREADY,
  output logic                       PSLVERR,
  output logic [`DATA_WIDTH-1:0]     PRDATA
);
  import uartPkg::*;

  logic dataWait;
  logic ready;

  // Only DATA can stall, on a full TX FIFO or an empty RX FIFO.
  assign dataWait = (bus.sel == DATA) & (bus.write ? txFull : rxEmpty);
  assign ready    = ~(bus.access & dataWait);  // Faulted transfers never wait.

  assign bus.done = (bus.access | bus.fault) & ready;

  assign PREADY  = ready;
  assign PSLVERR = bus.done & bus.fault;
  assign PRDATA  = (bus.done && bus.access && !bus.write) ? regRead : '0;

endmodule

`default_nettype wire

// ==== design/syncFifo.sv ====
`default_nettype none

module syncFifo #(
  parameter type payloadT = logic [7:0],
  parameter int  depth    = 4
) (
  input wire logic    PCLK,
  input wire logic    PRESETn,
  input wire logic    push,
  input wire payloadT din,
  input wire logic    pop,
  output payloadT     dout,
  output logic        full,
  output logic        empty
);
  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

  payloadT             mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;
  logic                doPush;
  logic                doPop;

  assign full   = (count == (ptrWidth + 1)'(depth));
  assign empty  = (count == '0);
  assign doPush = push & ~full;   // Push while full is dropped.
  assign doPop  = pop & ~empty;
  assign dout   = mem[rdPtr];     // Head entry.

  always_ff @(posedge PCLK) begin
    if (doPush) begin
      mem[wrPtr] <= din;
    end
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/uartTx.sv ====
`default_nettype none

module uartTx (
  input wire logic        PCLK,
  input wire logic        PRESETn,
  input wire logic        txEn,
  input wire logic [19:0] baudDiv,
  input wire logic        empty,
  input wire logic [7:0]  din,
  output logic            pop,
  output logic            busy,
  output logic            TXD
);
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } txState;

  txState      state;
  logic [19:0] baudCnt;
  logic [2:0]  bitCnt;
  logic [7:0]  shiftReg;
  logic        bitEnd;

  assign bitEnd = (baudCnt == baudDiv - 20'd1);
  assign pop    = (state == TX_IDLE) & txEn & ~empty;
  assign busy   = (state != TX_IDLE);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state   <= TX_IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
    end else begin
      baudCnt <= (state == TX_IDLE || bitEnd) ? '0 : baudCnt + 20'd1;
      case (state)
        TX_IDLE: begin
          if (pop) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bitEnd) begin
            state  <= TX_DATA;
            bitCnt <= '0;
          end
        end
        TX_DATA: begin
          if (bitEnd) begin
            bitCnt <= bitCnt + 3'd1;
            if (bitCnt == 3'd7) begin
              state <= TX_STOP;
            end
          end
        end
        default: begin
          if (bitEnd) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge PCLK) begin
    if (pop) begin
      shiftReg <= din;
    end else if (state == TX_DATA && bitEnd) begin
      shiftReg <= shiftReg >> 1;  // LSB goes out first.
    end
  end

  always_comb begin
    case (state)
      TX_START: TXD = 1'b0;
      TX_DATA:  TXD = shiftReg[0];
      default:  TXD = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/uartRx.sv ====
`default_nettype none

module uartRx (
  input wire logic        PCLK,
  input wire logic        PRESETn,
  input wire logic        rxEn,
  input wire logic [19:0] baudDiv,
  input wire logic        RXD,
  output logic            push,
  output uartPkg::rxEntry entry
);
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rxState;

  rxState      state;
  logic        rxMeta;
  logic        rxSync;
  logic        rxPrev;
  logic [19:0] baudCnt;
  logic [2:0]  bitCnt;
  logic [7:0]  shiftReg;
  logic        halfEnd;
  logic        bitEnd;
  logic        stopSample;

  assign halfEnd    = (baudCnt == (baudDiv >> 1) - 20'd1);
  assign bitEnd     = (baudCnt == baudDiv - 20'd1);
  assign stopSample = (state == RX_STOP) & bitEnd;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      rxMeta <= 1'b1;  // Line idles high.
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= RXD;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state   <= RX_IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
      push    <= 1'b0;
    end else begin
      push    <= stopSample & rxEn;
      baudCnt <= baudCnt + 20'd1;
      case (state)
        RX_IDLE: begin
          baudCnt <= '0;
          if (rxEn && rxPrev && !rxSync) begin
            state <= RX_START;  // Falling edge of a start bit.
          end
        end
        RX_START: begin
          if (halfEnd) begin
            baudCnt <= '0;
            bitCnt  <= '0;
            state   <= rxSync ? RX_IDLE : RX_DATA;  // Glitch if high at mid-bit.
          end
        end
        RX_DATA: begin
          if (bitEnd) begin
            baudCnt <= '0;
            bitCnt  <= bitCnt + 3'd1;
            if (bitCnt == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (bitEnd) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge PCLK) begin
    if (state == RX_DATA && bitEnd) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
    if (stopSample) begin
      entry.data     <= shiftReg;
      entry.frameErr <= ~rxSync;
    end
  end

endmodule

`default_nettype wire

// ==== design/apbUart.sv ====
`default_nettype none
`include "uart_params.svh"

module apbUart (
  input wire logic                   PCLK,
  input wire logic                   PRESETn,
  input wire logic                   PSEL,
  input wire logic                   PENABLE,
  input wire logic                   PWRITE,
  input wire logic [`ADDR_WIDTH-1:0] PADDR,
  input wire logic [`DATA_WIDTH-1:0] PWDATA,
  output logic [`DATA_WIDTH-1:0]     PRDATA,
  output logic                       PREADY,
  output logic                       PSLVERR,
  output logic                       TXD,
  input wire logic                   RXD
);
  import uartPkg::*;

  regBusIf bus ();

  logic                   txFull;
  logic                   txEmpty;
  logic                   txPush;
  logic                   txPop;
  logic                   txBusy;
  logic                   txEn;
  logic [7:0]             txHead;
  logic                   rxEmpty;
  logic                   rxPush;
  logic                   rxPop;
  logic                   rxEn;
  rxEntry                 rxHead;
  rxEntry                 rxNew;
  logic [19:0]            baudDiv;
  logic [`DATA_WIDTH-1:0] regRead;

  apbDecode decode_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .bus     (bus.decoder)
  );

  regExecute execute_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .bus     (bus.execute),
    .txFull  (txFull),
    .rxEmpty (rxEmpty),
    .rxHead  (rxHead),
    .txBusy  (txBusy),
    .txPush  (txPush),
    .rxPop   (rxPop),
    .txEn    (txEn),
    .rxEn    (rxEn),
    .baudDiv (baudDiv),
    .regRead (regRead)
  );

  apbResult result_i (
    .bus     (bus.result),
    .txFull  (txFull),
    .rxEmpty (rxEmpty),
    .regRead (regRead),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .PRDATA  (PRDATA)
  );

  syncFifo #(
    .payloadT (logic [7:0]),
    .depth    (`FIFO_DEPTH)
  ) txFifo_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .push    (txPush),
    .din     (PWDATA[7:0]),  // Byte lane of a DATA write.
    .pop     (txPop),
    .dout    (txHead),
    .full    (txFull),
    .empty   (txEmpty)
  );

  syncFifo #(
    .payloadT (rxEntry),
    .depth    (`FIFO_DEPTH)
  ) rxFifo_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .push    (rxPush),
    .din     (rxNew),
    .pop     (rxPop),
    .dout    (rxHead),
    .full    (),
    .empty   (rxEmpty)
  );

  uartTx tx_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .txEn    (txEn),
    .baudDiv (baudDiv),
    .empty   (txEmpty),
    .din     (txHead),
    .pop     (txPop),
    .busy    (txBusy),
    .TXD     (TXD)
  );

  uartRx rx_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .rxEn    (rxEn),
    .baudDiv (baudDiv),
    .RXD     (RXD),
    .push    (rxPush),
    .entry   (rxNew)
  );

endmodule

`default_nettype wire

// ==== dv/apbUartTb.sv ====
`default_nettype none
`include "uart_params.svh"

module apbUartTb;
  timeunit 1ns;
  timeprecision 1ps;
  import uartPkg::*;

  localparam int bitLen      = 8;  // BAUDDIV used by the serial tests.
  localparam int frameCycles = 10 * bitLen;
  localparam int frameTotal  = 18;  // Frames sent over all tests.
  localparam int watchCycles = frameTotal * frameCycles + 6000;
  localparam int maxWait     = 2000;

  logic                   PCLK;
  logic                   PRESETn;
  logic                   PSEL;
  logic                   PENABLE;
  logic                   PWRITE;
  logic [`ADDR_WIDTH-1:0] PADDR;
  logic [`DATA_WIDTH-1:0] PWDATA;
  logic [`DATA_WIDTH-1:0] PRDATA;
  logic                   PREADY;
  logic                   PSLVERR;
  logic                   TXD;
  logic                   RXD;
  logic                   loopback;
  logic                   serLine;

  integer     seed      = 32'hf259e1e0;
  int         errCount  = 0;
  int         passCount = 0;
  int         failCount = 0;
  string      curTest;
  logic [7:0] txSeen [$];  // Bytes decoded from TXD.

  assign RXD = loopback ? TXD : serLine;

  apbUart dut_i (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .TXD     (TXD),
    .RXD     (RXD)
  );

  always #50 PCLK = ~PCLK;

  task automatic reportErr(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
    $display("ERR %s %s: expected 0x%0h, actual 0x%0h", curTest, what, expVal, actVal);
    errCount++;
  endtask

  task automatic noteFail(input string msg);
    $display("%s: %s", curTest, msg);
    errCount++;
  endtask

  task automatic finishTest(input int errBefore);
    if (errCount == errBefore) begin
      passCount++;
      $display("PASS %s", curTest);
    end else begin
      failCount++;
      $display("FAIL %s with %0d errors", curTest, errCount - errBefore);
    end
  endtask

  // One transfer, abandoned if PREADY stays low for more than limit cycles.
  task automatic apbXfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                         input int limit, output logic [31:0] rdata, output logic err,
                         output logic ready, output int waits);
    waits = 0;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= write;
    PADDR   <= addr;
    PWDATA  <= wdata;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    @(negedge PCLK);
    while (!PREADY && waits < limit) begin
      waits++;
      @(negedge PCLK);
    end
    ready = PREADY;
    rdata = PRDATA;
    err   = PSLVERR;
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    if (!ready) begin
      @(posedge PCLK);  // Decoder needs an idle cycle to leave ERROR.
    end
  endtask

  task automatic apbWrite(input logic [3:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] rdata;
    logic        ready;
    int          waits;
    apbXfer(1'b1, addr, wdata, maxWait, rdata, err, ready, waits);
    if (!ready) begin
      noteFail($sformatf("write to 0x%0h never saw PREADY", addr));
    end
  endtask

  task automatic apbRead(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
    logic ready;
    int   waits;
    apbXfer(1'b0, addr, 32'h0, maxWait, rdata, err, ready, waits);
    if (!ready) begin
      noteFail($sformatf("read from 0x%0h never saw PREADY", addr));
    end
  endtask

  task automatic waitRxAvail(output logic [31:0] status);
    logic err;
    int   tries;
    tries  = 0;
    status = '0;
    while (!status[statRxAvail] && tries < 200) begin
      apbRead(`STATUS_OFFSET, status, err);
      tries++;
    end
    if (!status[statRxAvail]) begin
      noteFail("no byte arrived in the receive FIFO");
    end
  endtask

  task automatic waitTxBytes(input int n);
    int guard;
    guard = 0;
    while (txSeen.size() < n && guard < n * frameCycles * 2 + 200) begin
      @(posedge PCLK);
      guard++;
    end
    if (txSeen.size() < n) begin
      noteFail($sformatf("monitor decoded %0d of %0d frames", txSeen.size(), n));
    end
  endtask

  task automatic sendFrame(input logic [7:0] data, input logic stopBit);
    logic [9:0] bits;
    bits = {stopBit, data, 1'b0};
    @(posedge PCLK);
    for (int i = 0; i < 10; i++) begin
      serLine <= bits[i];
      repeat (bitLen) @(posedge PCLK);
    end
    serLine <= 1'b1;
  endtask

  // Frame decoder on TXD, sampling at mid-bit.
  initial begin
    logic [7:0] monByte;
    forever begin
      @(negedge TXD);
      repeat (bitLen / 2) @(negedge PCLK);
      if (TXD !== 1'b0) begin
        noteFail("start bit on TXD ended before mid-bit");
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (bitLen) @(negedge PCLK);
          monByte[i] = TXD;
        end
        repeat (bitLen) @(negedge PCLK);
        if (TXD !== 1'b1) begin
          noteFail("stop bit on TXD was low");
        end
        txSeen.push_back(monByte);
      end
    end
  end

  task automatic resetValues();
    logic [31:0] rd;
    logic        err;
    int          errBefore;
    errBefore = errCount;
    curTest   = "resetValues";
    @(negedge PCLK);
    if (TXD !== 1'b1) reportErr("TXD", 1, TXD);
    if (PREADY !== 1'b1) reportErr("idle PREADY", 1, PREADY);
    if (PSLVERR !== 1'b0) reportErr("idle PSLVERR", 0, PSLVERR);
    apbRead(`CNTRL_OFFSET, rd, err);
    if (rd !== 32'h0) reportErr("CNTRL", 0, rd);
    apbRead(`BAUDDIV_OFFSET, rd, err);
    if (rd !== 32'h0) reportErr("BAUDDIV", 0, rd);
    apbRead(`STATUS_OFFSET, rd, err);
    if (rd !== 32'h0) reportErr("STATUS", 0, rd);
    if (err !== 1'b0) reportErr("PSLVERR", 0, err);
    finishTest(errBefore);
  endtask

  task automatic registerMasking();
    logic [31:0] rd;
    logic        err;
    int          errBefore;
    errBefore = errCount;
    curTest   = "registerMasking";
    apbWrite(`CNTRL_OFFSET, 32'hFFFF_FFFF, err);
    apbWrite(`BAUDDIV_OFFSET, 32'hFFFF_FFFF, err);
    apbRead(`CNTRL_OFFSET, rd, err);
    if (rd !== 32'hF) reportErr("CNTRL", 32'hF, rd);
    apbRead(`BAUDDIV_OFFSET, rd, err);
    if (rd !== 32'hF_FFFF) reportErr("BAUDDIV", 32'hF_FFFF, rd);
    apbWrite(`CNTRL_OFFSET, 32'h0, err);
    apbWrite(`BAUDDIV_OFFSET, bitLen, err);
    apbWrite(`STATUS_OFFSET, 32'hFFFF_FFFF, err);
    if (err !== 1'b0) reportErr("STATUS write PSLVERR", 0, err);
    apbRead(`STATUS_OFFSET, rd, err);
    if (rd !== 32'h0) reportErr("STATUS", 0, rd);
    apbRead(`CNTRL_OFFSET, rd, err);
    if (rd !== 32'h0) reportErr("CNTRL after STATUS write", 0, rd);
    apbRead(`BAUDDIV_OFFSET, rd, err);
    if (rd !== bitLen) reportErr("BAUDDIV after STATUS write", bitLen, rd);
    finishTest(errBefore);
  endtask

  task automatic transmitFraming();
    logic [7:0] sent [3];
    logic       err;
    int         errBefore;
    errBefore = errCount;
    curTest   = "transmitFraming";
    txSeen.delete();
    apbWrite(`BAUDDIV_OFFSET, bitLen, err);
    apbWrite(`CNTRL_OFFSET, 32'h1, err);  // Transmitter only.
    for (int i = 0; i < 3; i++) begin
      sent[i] = 8'($random(seed));
      apbWrite(`DATA_OFFSET, {24'h0, sent[i]}, err);
    end
    waitTxBytes(3);
    for (int i = 0; i < 3 && i < txSeen.size(); i++) begin
      if (txSeen[i] !== sent[i]) reportErr($sformatf("frame %0d", i), sent[i], txSeen[i]);
    end
    finishTest(errBefore);
  endtask

  task automatic loopbackReceive();
    logic [7:0]  b;
    logic [31:0] rd;
    logic [31:0] status;
    logic        err;
    int          errBefore;
    errBefore = errCount;
    curTest   = "loopbackReceive";
    loopback <= 1'b1;
    apbWrite(`CNTRL_OFFSET, 32'h3, err);
    for (int i = 0; i < 8; i++) begin
      b = 8'($random(seed));
      apbWrite(`DATA_OFFSET, {24'h0, b}, err);
      waitRxAvail(status);
      if (status[statFrameErr] !== 1'b0) reportErr("frameErr", 0, status[statFrameErr]);
      apbRead(`DATA_OFFSET, rd, err);
      if (rd !== {24'h0, b}) reportErr($sformatf("byte %0d", i), b, rd);
    end
    loopback <= 1'b0;
    b = 8'($random(seed));
    sendFrame(b, 1'b0);  // Stop bit forced low.
    waitRxAvail(status);
    if (status[statFrameErr] !== 1'b1) reportErr("bad stop frameErr", 1, status[statFrameErr]);
    apbRead(`DATA_OFFSET, rd, err);
    if (rd !== {24'h0, b}) reportErr("bad stop byte", b, rd);
    finishTest(errBefore);
  endtask

  task automatic backPressure();
    logic [7:0]  sent [$];
    logic [7:0]  b;
    logic [31:0] rd;
    logic        err;
    logic        ready;
    int          waits;
    int          errBefore;
    errBefore = errCount;
    curTest   = "backPressure";
    txSeen.delete();
    apbWrite(`CNTRL_OFFSET, 32'h2, err);  // Receiver only.
    for (int i = 0; i <= `FIFO_DEPTH; i++) begin
      sent.push_back(8'($random(seed)));
    end
    for (int i = 0; i < `FIFO_DEPTH; i++) begin
      apbWrite(`DATA_OFFSET, {24'h0, sent[i]}, err);
    end
    apbRead(`STATUS_OFFSET, rd, err);
    if (rd[statTxFull] !== 1'b1) reportErr("txFull", 1, rd[statTxFull]);
    apbXfer(1'b1, `DATA_OFFSET, {24'h0, sent[`FIFO_DEPTH]}, 20, rd, err, ready, waits);
    if (ready !== 1'b0) noteFail("write to a full transmit FIFO did not stall");
    apbWrite(`CNTRL_OFFSET, 32'h3, err);
    apbWrite(`DATA_OFFSET, {24'h0, sent[`FIFO_DEPTH]}, err);
    if (err !== 1'b0) reportErr("stalled write PSLVERR", 0, err);
    waitTxBytes(`FIFO_DEPTH + 1);
    for (int i = 0; i < sent.size() && i < txSeen.size(); i++) begin
      if (txSeen[i] !== sent[i]) reportErr($sformatf("frame %0d", i), sent[i], txSeen[i]);
    end
    b = 8'($random(seed));
    fork
      apbXfer(1'b0, `DATA_OFFSET, 32'h0, maxWait, rd, err, ready, waits);
      begin
        repeat (10) @(posedge PCLK);
        sendFrame(b, 1'b1);
      end
    join
    if (!ready) noteFail("DATA read on an empty receive FIFO never completed");
    if (waits == 0) noteFail("DATA read on an empty receive FIFO did not stall");
    if (rd !== {24'h0, b}) reportErr("stalled read", b, rd);
    finishTest(errBefore);
  endtask

  task automatic errorResponses();
    logic [31:0] rd;
    logic        err;
    int          errBefore;
    errBefore = errCount;
    curTest   = "errorResponses";
    apbWrite(4'h2, 32'hFFFF_FFFF, err);
    if (err !== 1'b1) reportErr("PSLVERR at 0x2", 1, err);
    apbRead(`CNTRL_OFFSET, rd, err);
    if (rd !== 32'h3) reportErr("CNTRL after bad write", 3, rd);
    apbRead(`BAUDDIV_OFFSET, rd, err);
    if (rd !== bitLen) reportErr("BAUDDIV after bad write", bitLen, rd);
    @(posedge PCLK);
    PSEL    <= 1'b1;  // Setup with no access phase after it.
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= `CNTRL_OFFSET;
    @(posedge PCLK);
    PSEL <= 1'b0;
    apbRead(`CNTRL_OFFSET, rd, err);
    if (err !== 1'b1) reportErr("PSLVERR after broken setup", 1, err);
    apbRead(`CNTRL_OFFSET, rd, err);
    if (err !== 1'b0) reportErr("PSLVERR once idle", 0, err);
    if (rd !== 32'h3) reportErr("CNTRL once idle", 3, rd);
    finishTest(errBefore);
  endtask

  initial begin
    PCLK     = 1'b0;
    PRESETn  = 1'b0;
    PSEL     = 1'b0;
    PENABLE  = 1'b0;
    PWRITE   = 1'b0;
    PADDR    = '0;
    PWDATA   = '0;
    loopback = 1'b0;
    serLine  = 1'b1;  // Idle line.
    repeat (10) @(posedge PCLK);
    PRESETn <= 1'b1;
    resetValues();
    registerMasking();
    transmitFraming();
    loopbackReceive();
    backPressure();
    errorResponses();
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Frame time of every test plus room for register traffic.
  initial begin
    #(watchCycles * 100);
    $display("Watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/uartPkg.sv
design/regBusIf.sv
design/apbDecode.sv
design/regExecute.sv
design/apbResult.sv
design/syncFifo.sv
design/uartTx.sv
design/uartRx.sv
design/apbUart.sv
dv/apbUartTb.sv

// ==== Bender.yml ====
package:
  name: apb_uart
  description: "APB slave UART with 8N1 transmitter and receiver"

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/uartPkg.sv
      - design/regBusIf.sv
      - design/apbDecode.sv
      - design/regExecute.sv
      - design/apbResult.sv
      - design/syncFifo.sv
      - design/uartTx.sv
      - design/uartRx.sv
      - design/apbUart.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/apbUartTb.sv
